/* compile.f */
hw/jesd_tpl_pkg.sv
hw/dac_sample_format.sv
hw/dac_framer.sv
hw/lane_scrambler.sv
hw/jesd_tpl_dac_tx.sv
sim/clk_gen.sv
sim/jesd_tpl_dac_tx_properties.sv
sim/tb_jesd_tpl_dac_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the transport layer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
  --top-module tb_jesd_tpl_dac_tx \
  -f compile.f \
  -Mdir obj_dir \
  -o sim_tb

# Assertion failures are counted by the testbench, so keep running past them
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished cleanly"

/* sim/tb_jesd_tpl_dac_tx.sv */
// DAC transport layer testbench with random stimulus, reference model, checker and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_jesd_tpl_dac_tx;
  import jesd_tpl_pkg::*;

  // ************************************************************************
  // Configuration and run length
  // ************************************************************************

  localparam int NUM_LANES = 4;
  localparam int NUM_CHANNELS = 2;
  localparam int BUS_W = NUM_LANES * LANE_W;
  localparam int DPW = 2 * NUM_LANES / NUM_CHANNELS;
  localparam int H = (NUM_LANES > NUM_CHANNELS) ? NUM_LANES / NUM_CHANNELS / 2 : 1;
  localparam int RESET_CYC = 5;
  localparam int IDLE_CYC = 10;
  localparam int MAX_GAP = 3;
  localparam int P2_WORDS = 40;
  localparam int P3_ROUNDS = 8;
  localparam int P3_WORDS = 12;
  localparam int P4_WORDS = 60;
  localparam int P5_WORDS = 300;
  localparam int P5_RECONF = 25;
  localparam int DRAIN_CYC = PIPE_LATENCY + 4;
  localparam int NUM_DRAINS = 3 + P3_ROUNDS + P5_WORDS / P5_RECONF;
  localparam int NUM_RECONF = P3_ROUNDS + 1 + P5_WORDS / P5_RECONF;
  // Worst case length of every phase plus a margin
  localparam int CYCLE_LIMIT = RESET_CYC + IDLE_CYC + P2_WORDS + NUM_RECONF
    + (P3_ROUNDS * P3_WORDS + P4_WORDS + P5_WORDS) * (MAX_GAP + 1)
    + NUM_DRAINS * (DRAIN_CYC + 1) + 100;

  logic             clk;
  logic             arst_n;
  logic             offset_binary;
  logic [NUM_CHANNELS-1:0] chan_enable;
  logic             scramble_en;
  logic             dac_valid;
  logic [BUS_W-1:0] dac_data;
  logic             link_valid;
  logic [BUS_W-1:0] link_data;

  // Model and scoreboard
  logic [14:0]      scr_state [NUM_LANES];
  logic [BUS_W-1:0] exp_q [$];
  int               stamp_q [$];
  logic [BUS_W-1:0] exp_word;
  int               stamp;
  int               cycle_cnt = 0;
  int               err_cnt = 0;
  int               checked = 0;
  bit               out_seen = 1'b0;

  clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYC)) clk_gen_i (.clk(clk), .arst_n(arst_n));

  jesd_tpl_dac_tx #(
    .NUM_LANES    (NUM_LANES),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) dut_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .offset_binary (offset_binary),
    .chan_enable   (chan_enable),
    .scramble_en   (scramble_en),
    .dac_valid     (dac_valid),
    .dac_data      (dac_data),
    .link_valid    (link_valid),
    .link_data     (link_data)
  );

  // jesd_tpl_dac_tx has the single instance dut_i here
  bind jesd_tpl_dac_tx jesd_tpl_dac_tx_properties #(.NUM_LANES(NUM_LANES)) props_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .scramble_en (scramble_en),
    .dac_valid   (dac_valid),
    .link_valid  (link_valid),
    .link_data   (link_data)
  );

  // ************************************************************************
  // Reference model
  // ************************************************************************

  // Blank disabled channels and flip the sign bit for offset binary
  function automatic logic [BUS_W-1:0] format_samples(input logic [BUS_W-1:0] din);
    logic [BUS_W-1:0] dout;
    logic [15:0]      flip;
    flip = offset_binary ? 16'h8000 : 16'h0000;
    for (int k = 0; k < BUS_W / 16; k++) begin
      dout[k*16 +: 16] = chan_enable[k / DPW] ? (din[k*16 +: 16] ^ flip) : 16'h0000;
    end
    return dout;
  endfunction

  // High octet first
  // Wide case puts high octets on even lanes and low octets on the next lane
  function automatic logic [BUS_W-1:0] map_octets(input logic [BUS_W-1:0] din);
    logic [BUS_W-1:0] dout;
    logic [15:0]      s;
    int               k;
    int               lane;
    int               pos;
    dout = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int j = 0; j < DPW; j++) begin
        k = c * DPW + j;
        s = din[k*16 +: 16];
        if (NUM_LANES > NUM_CHANNELS) begin
          lane = 2 * (c * H + j % H);
          pos = (j / H) * 8;
          dout[lane*32 + pos +: 8] = s[15:8];
          dout[(lane+1)*32 + pos +: 8] = s[7:0];
        end else begin
          dout[k*16 +: 8] = s[15:8];
          dout[k*16 + 8 +: 8] = s[7:0];
        end
      end
    end
    return dout;
  endfunction

  // Serial 1 + x^14 + x^15 per lane with the MSB first
  // History advances only when scrambling is enabled
  function automatic logic [BUS_W-1:0] scramble_lanes(input logic [BUS_W-1:0] din);
    logic [BUS_W-1:0] dout;
    logic [14:0]      hist;
    logic             b;
    if (!scramble_en) begin
      return din;
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      // hist[n] is the scrambled bit n+1 positions back
      hist = scr_state[l];
      for (int i = 31; i >= 0; i--) begin
        b = din[l*32 + i] ^ hist[13] ^ hist[14];
        dout[l*32 + i] = b;
        hist = {hist[13:0], b};
      end
      scr_state[l] = hist;
    end
    return dout;
  endfunction

  // ************************************************************************
  // Monitor sampled on the falling edge
  // ************************************************************************

  always @(negedge clk) begin
    if (!arst_n) begin
      if (link_valid !== 1'b0) begin
        $display("[ERROR] %0t link_valid expected 0 actual %b", $time, link_valid);
        err_cnt++;
      end
      if (link_data !== '0) begin
        $display("[ERROR] %0t link_data expected 0 actual %h", $time, link_data);
        err_cnt++;
      end
    end else if (link_valid) begin
      out_seen = 1'b1;
      if (exp_q.size() == 0) begin
        $display("%0t: link_valid arrived with no word outstanding", $time);
        err_cnt++;
      end else begin
        exp_word = exp_q.pop_front();
        stamp = stamp_q.pop_front();
        checked++;
        if (link_data !== exp_word) begin
          $display("[ERROR] %0t link_data expected %h actual %h", $time, exp_word, link_data);
          err_cnt++;
        end
        if (cycle_cnt - stamp != PIPE_LATENCY) begin
          $display("[ERROR] %0t link_valid latency expected %0d actual %0d",
                   $time, PIPE_LATENCY, cycle_cnt - stamp);
          err_cnt++;
        end
      end
    end else if (!out_seen && link_data !== '0) begin
      $display("[ERROR] %0t link_data expected 0 actual %h", $time, link_data);
      err_cnt++;
    end
    // Model runs on the strobe with the configuration of that cycle
    if (arst_n && dac_valid) begin
      exp_q.push_back(scramble_lanes(map_octets(format_samples(dac_data))));
      stamp_q.push_back(cycle_cnt);
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d words still expected", cycle_cnt, exp_q.size());
      $display("Checked %0d words, %0d errors", checked, err_cnt + 1);
      $display("Test failed");
      $finish;
    end
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  task automatic idle_cycle();
    @(posedge clk);
    #1 dac_valid = 1'b0;
  endtask

  task automatic strobe_cycle(input int gap);
    @(posedge clk);
    #1 dac_valid = 1'b1;
    for (int l = 0; l < NUM_LANES; l++) begin
      dac_data[l*32 +: 32] = $urandom;
    end
    repeat (gap) idle_cycle();
  endtask

  // Idle until the pipeline is empty or the drain bound runs out
  task automatic drain();
    idle_cycle();
    for (int n = 0; n < DRAIN_CYC && exp_q.size() != 0; n++) begin
      idle_cycle();
    end
  endtask

  task automatic reconfigure(input logic ob, input logic [NUM_CHANNELS-1:0] en, input logic se);
    @(posedge clk);
    #1;
    dac_valid = 1'b0;
    offset_binary = ob;
    chan_enable = en;
    scramble_en = se;
  endtask

  initial begin
    void'($urandom(32'h135f_6e17));
    offset_binary = 1'b0;
    chan_enable = '1;
    scramble_en = 1'b0;
    dac_valid = 1'b0;
    dac_data = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      scr_state[l] = '0;
    end
    @(posedge arst_n);
    repeat (IDLE_CYC) idle_cycle();
    // Framing only with back to back strobes
    for (int i = 0; i < P2_WORDS; i++) begin
      strobe_cycle(0);
    end
    drain();
    // Format conversion and blanking
    for (int r = 0; r < P3_ROUNDS; r++) begin
      reconfigure(1'($urandom), NUM_CHANNELS'($urandom), 1'b0);
      for (int i = 0; i < P3_WORDS; i++) begin
        strobe_cycle(int'($urandom_range(MAX_GAP, 0)));
      end
      drain();
    end
    // Scrambling with gaps
    reconfigure(1'b0, '1, 1'b1);
    for (int i = 0; i < P4_WORDS; i++) begin
      strobe_cycle(int'($urandom_range(MAX_GAP, 0)));
    end
    drain();
    // Mixed traffic with configuration changes only while idle
    for (int i = 0; i < P5_WORDS; i++) begin
      if (i % P5_RECONF == 0) begin
        drain();
        reconfigure(1'($urandom), NUM_CHANNELS'($urandom), 1'($urandom));
      end
      strobe_cycle(int'($urandom_range(MAX_GAP, 0)));
    end
    drain();
    if (exp_q.size() != 0) begin
      $display("%0d expected words never came out of the pipeline", exp_q.size());
      err_cnt++;
    end
    err_cnt += dut_i.props_i.fail_cnt;
    $display("Checked %0d words, %0d errors", checked, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/jesd_tpl_dac_tx_properties.sv */
// Concurrent assertions on the transport layer top-level strobes and output data

`timescale 1ns/1ps
`default_nettype none

module jesd_tpl_dac_tx_properties
  import jesd_tpl_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input wire logic                        clk,
  input wire logic                        arst_n,
  input wire logic                        scramble_en,
  input wire logic                        dac_valid,
  input wire logic                        link_valid,
  input wire logic [NUM_LANES*LANE_W-1:0] link_data
);

  // Failed assertion count, read by the testbench at the end of the run
  int fail_cnt = 0;

  // ************************************************************************
  // Strobe timing
  // ************************************************************************

  // Every input strobe leaves the pipeline exactly PIPE_LATENCY cycles later
  a_latency : assert property (@(posedge clk) disable iff (!arst_n)
    link_valid == $past(dac_valid, PIPE_LATENCY))
  else begin
    $error("link_valid does not follow dac_valid by the pipeline latency");
    fail_cnt++;
  end

  // No output strobe while in reset
  a_reset_quiet : assert property (@(posedge clk) !arst_n |-> !link_valid)
  else begin
    $error("link_valid high during reset");
    fail_cnt++;
  end

  // ************************************************************************
  // Output hold
  // ************************************************************************

  // Bypassed and idle, the lane bus keeps its last word
  a_data_hold : assert property (@(posedge clk) disable iff (!arst_n)
    (!scramble_en && !link_valid) |-> $stable(link_data))
  else begin
    $error("link_data moved without a strobe while bypassed");
    fail_cnt++;
  end

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
// Testbench clock source and power-on reset generator

`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset low from time zero, released just after a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* hw/jesd_tpl_dac_tx.sv */
// Transmit transport layer top: sample format, framer and scrambler in a chain

`timescale 1ns/1ps
`default_nettype none

module jesd_tpl_dac_tx
  import jesd_tpl_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int NUM_CHANNELS = 2
) (
  // clk is lane rate / 40
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  // Quasi-static configuration
  input  wire logic                        offset_binary,
  input  wire logic [NUM_CHANNELS-1:0]     chan_enable,
  input  wire logic                        scramble_en,
  // DAC sample interface
  input  wire logic                        dac_valid,
  input  wire logic [NUM_LANES*LANE_W-1:0] dac_data,
  // Lane data toward the link layer
  output logic                             link_valid,
  output logic [NUM_LANES*LANE_W-1:0]      link_data
);

  // Stage to stage connections
  logic                        fmt_valid;
  logic [NUM_LANES*LANE_W-1:0] fmt_data;
  logic                        frm_valid;
  logic [NUM_LANES*LANE_W-1:0] frm_data;

  // Stage 1
  dac_sample_format #(
    .NUM_LANES    (NUM_LANES),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) sample_format_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .offset_binary (offset_binary),
    .chan_enable   (chan_enable),
    .in_valid      (dac_valid),
    .in_data       (dac_data),
    .out_valid     (fmt_valid),
    .out_data      (fmt_data)
  );

  // Stage 2
  dac_framer #(
    .NUM_LANES    (NUM_LANES),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) framer_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (fmt_valid),
    .in_data   (fmt_data),
    .out_valid (frm_valid),
    .out_data  (frm_data)
  );

  // Stage 3
  lane_scrambler #(
    .NUM_LANES (NUM_LANES)
  ) scrambler_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .scramble_en (scramble_en),
    .in_valid    (frm_valid),
    .in_data     (frm_data),
    .out_valid   (link_valid),
    .out_data    (link_data)
  );

endmodule

`default_nettype wire

/* hw/lane_scrambler.sv */
// Stage 3: per-lane self-synchronous scrambler 1 + x^14 + x^15 with bypass

`timescale 1ns/1ps
`default_nettype none

module lane_scrambler
  import jesd_tpl_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  // clk is lane rate / 40
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  // Bypass when clear
  input  wire logic                        scramble_en,
  // Framed lane words
  input  wire logic                        in_valid,
  input  wire logic [NUM_LANES*LANE_W-1:0] in_data,
  // Toward the link layer
  output logic                             out_valid,
  output logic [NUM_LANES*LANE_W-1:0]      out_data
);

  // Scrambler memory, one bit per polynomial order
  localparam int STATE_W = 15;

  // Bit 0 is the most recent scrambled bit, bit 14 the oldest
  logic [NUM_LANES-1:0][STATE_W-1:0] state_q;
  logic [NUM_LANES-1:0][STATE_W-1:0] state_d;
  logic [NUM_LANES*LANE_W-1:0]       scr_data;

  // ************************************************************************
  // Scrambler datapath
  // ************************************************************************

  // Unrolled serial recurrence, MSB of each lane word goes first
  always_comb begin
    logic [STATE_W-1:0] s;
    logic               b;
    for (int l = 0; l < NUM_LANES; l++) begin
      s = state_q[l];
      for (int i = LANE_W - 1; i >= 0; i--) begin
        // Taps at distance 14 and 15
        b = in_data[l*LANE_W + i] ^ s[13] ^ s[14];
        scr_data[l*LANE_W + i] = b;
        s = {s[STATE_W-2:0], b};
      end
      state_d[l] = s;
    end
  end

  // ************************************************************************
  // Registers
  // ************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
      state_q   <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        // Bypass still costs one cycle
        out_data <= scramble_en ? scr_data : in_data;
        // State frozen while bypassed or idle
        if (scramble_en) begin
          state_q <= state_d;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dac_framer.sv */
// Stage 2 framer that maps converter samples to lane octets and registers them

`timescale 1ns/1ps
`default_nettype none

module dac_framer
  import jesd_tpl_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int NUM_CHANNELS = 2
) (
  // clk is lane rate / 40
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  // Formatted samples
  input  wire logic                        in_valid,
  input  wire logic [NUM_LANES*LANE_W-1:0] in_data,
  // Lane octets to the scrambler
  output logic                             out_valid,
  output logic [NUM_LANES*LANE_W-1:0]      out_data
);

  localparam int DATA_PATH_WIDTH = 2 * NUM_LANES / NUM_CHANNELS;
  // With more lanes than channels a channel spreads over several lanes
  localparam bit HD = NUM_LANES > NUM_CHANNELS;
  localparam int H = HD ? NUM_LANES / NUM_CHANNELS / 2 : 1;
  // Distance between the high and low octet of one sample
  localparam int OCT_OFFSET = HD ? 32 : 8;
  localparam int SAMPLES_PER_LANE = LANE_W / SAMPLE_W;

  lane_word_t [NUM_LANES-1:0] smp_words;
  lane_word_t [NUM_LANES-1:0] oct_words;

  // Input read through the sample view
  assign smp_words = in_data;

  // ************************************************************************
  // Octet mapping with the high octet first
  // ************************************************************************

  always_comb begin
    int k;
    int oct0;
    int oct1;
    oct_words = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int j = 0; j < DATA_PATH_WIDTH; j++) begin
        k = j + c * DATA_PATH_WIDTH;
        // Bit position of the high octet in the lane bus
        oct0 = HD ? ((c * H + j % H) * 64 + (j / H) * 8) : (k * 16);
        oct1 = oct0 + OCT_OFFSET;
        oct_words[oct0 / LANE_W].octet[(oct0 % LANE_W) / OCTET_W] =
          smp_words[k / SAMPLES_PER_LANE].sample[k % SAMPLES_PER_LANE][SAMPLE_W-1 -: OCTET_W];
        oct_words[oct1 / LANE_W].octet[(oct1 % LANE_W) / OCTET_W] =
          smp_words[k / SAMPLES_PER_LANE].sample[k % SAMPLES_PER_LANE][OCTET_W-1:0];
      end
    end
  end

  // Output register with the octet view flattened onto the lane bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_data <= oct_words;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dac_sample_format.sv */
// Stage 1: sample format conversion and channel blanking, registered

`timescale 1ns/1ps
`default_nettype none

module dac_sample_format
  import jesd_tpl_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int NUM_CHANNELS = 2
) (
  // clk is lane rate / 40
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  // Quasi-static configuration
  input  wire logic                        offset_binary,
  input  wire logic [NUM_CHANNELS-1:0]     chan_enable,
  // Samples from the DAC core
  input  wire logic                        in_valid,
  input  wire logic [NUM_LANES*LANE_W-1:0] in_data,
  // To the framer
  output logic                             out_valid,
  output logic [NUM_LANES*LANE_W-1:0]      out_data
);

  // Samples per channel per clock
  localparam int DATA_PATH_WIDTH = 2 * NUM_LANES / NUM_CHANNELS;
  localparam int NUM_SAMPLES = NUM_LANES * LANE_W / SAMPLE_W;

  logic [NUM_LANES*LANE_W-1:0] fmt_next;

  // Per sample conversion
  always_comb begin
    logic [SAMPLE_W-1:0] smp;
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      smp = in_data[k*SAMPLE_W +: SAMPLE_W];
      // Sample k belongs to channel k / DATA_PATH_WIDTH
      if (!chan_enable[k / DATA_PATH_WIDTH]) begin
        smp = '0;
      end else if (offset_binary) begin
        // Two's complement to offset binary, flip the sign bit
        smp[SAMPLE_W-1] = ~smp[SAMPLE_W-1];
      end
      fmt_next[k*SAMPLE_W +: SAMPLE_W] = smp;
    end
  end

  // Pipeline register, data only loads on a strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_data <= fmt_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/jesd_tpl_pkg.sv */
// Transport layer package: width constants, pipeline latency and the lane word union

`default_nettype none

package jesd_tpl_pkg;

  // ************************************************************************
  // Width constants
  // ************************************************************************

  // Converter resolution
  localparam int SAMPLE_W = 16;
  // Lane word per clock, four octets at lane rate / 40
  localparam int LANE_W = 32;
  localparam int OCTET_W = 8;

  // Input strobe to output strobe, one cycle per stage
  localparam int PIPE_LATENCY = 3;

  // ************************************************************************
  // Lane word
  // ************************************************************************

  // Same 32 bits seen as two samples or as four octets
  // Index 0 sits in the low half / low byte in both views
  typedef union packed {
    logic [LANE_W/SAMPLE_W-1:0][SAMPLE_W-1:0] sample;
    logic [LANE_W/OCTET_W-1:0][OCTET_W-1:0] octet;
  } lane_word_t;

endpackage

`default_nettype wire
